// File: dv/cart_slot_properties.sv
// Assertions on the slot memory
// Read-to-data timing, reset state, idle mapper addresses
`timescale 1ns/1ps

module cart_slot_properties (
    input logic                  cpu_bus,
    input logic                  arst_n,
    input cart_pkg::cpu_req_t    bus,
    input cart_pkg::mapper_out_t out_gm2,
    input cart_pkg::mapper_out_t out_kon,
    input cart_pkg::mapper_out_t out_a8,
    input logic                  rd_valid
);
    import cart_pkg::*;

    int unsigned fail_cnt = 0;                         // Read back by the testbench

    logic [2:0] sel;                                   // Chip select per mapper
    logic       rd_req;                                // Read that must be answered

    function automatic logic is_read(input mapper_out_t o);
        return (o.ram_cs || o.sram_cs) && o.rnw;
    endfunction

    assign sel    = {out_gm2.ram_cs || out_gm2.sram_cs,
                     out_kon.ram_cs || out_kon.sram_cs,
                     out_a8.ram_cs  || out_a8.sram_cs};
    assign rd_req = bus.mreq && bus.rd &&
                    (is_read(out_gm2) || is_read(out_kon) || is_read(out_a8));

    // Data exactly one cycle after the strobe
    read_gets_data: assert property (@(posedge cpu_bus) disable iff (!arst_n)
        rd_req |=> rd_valid)
        else begin
            $error("Read under chip select without rd_valid one cycle later");
            fail_cnt++;
        end

    no_spurious_valid: assert property (@(posedge cpu_bus) disable iff (!arst_n)
        !rd_req |=> !rd_valid)
        else begin
            $error("rd_valid raised without a preceding read");
            fail_cnt++;
        end

    // No disable here, reset itself is checked
    valid_low_in_reset: assert property (@(posedge cpu_bus) !arst_n |-> !rd_valid)
        else begin
            $error("rd_valid high during reset");
            fail_cnt++;
        end

    gm2_idle_addr: assert property (@(posedge cpu_bus) disable iff (!arst_n)
        !sel[2] |-> out_gm2.addr == ADDR_IDLE)
        else begin
            $error("GameMaster2 address not idle without select");
            fail_cnt++;
        end

    kon_idle_addr: assert property (@(posedge cpu_bus) disable iff (!arst_n)
        !sel[1] |-> out_kon.addr == ADDR_IDLE)
        else begin
            $error("Konami address not idle without select");
            fail_cnt++;
        end

    a8_idle_addr: assert property (@(posedge cpu_bus) disable iff (!arst_n)
        !sel[0] |-> out_a8.addr == ADDR_IDLE)
        else begin
            $error("ASCII8 address not idle without select");
            fail_cnt++;
        end

endmodule

bind cart_memory cart_slot_properties u_props (
    .cpu_bus  (cpu_bus),
    .arst_n   (arst_n),
    .bus      (bus),
    .out_gm2  (out_gm2),
    .out_kon  (out_kon),
    .out_a8   (out_a8),
    .rd_valid (rd_valid)
);

// File: dv/cart_slot_tb.sv
// Cartridge slot testbench
// Clock, reset, ROM image load, bank model, directed tests per mapper, watchdog
`timescale 1ns/1ps

module cart_slot_tb;
    import cart_pkg::*;

    localparam int          ROM_DEPTH   = 2 ** ROM_AW;
    localparam int          SRAM_DEPTH  = 2 ** SRAM_AW;
    localparam logic [31:0] SEED        = 32'd66;
    localparam int          RD_TIMEOUT  = 4;           // Cycles to wait for read data
    localparam int          MAX_CPU_ACC = 200;         // Upper bound over all CPU tests
    // Every load byte and CPU access gets 10 cycles, plus reset and slack
    localparam int          WD_NS = ((ROM_DEPTH + MAX_CPU_ACC) * 10 + 2000) * 10;
    localparam cpu_req_t    BUS_IDLE  = '0;
    localparam load_t       LOAD_IDLE = '0;

    logic        cpu_bus;
    logic        arst_n;
    cpu_req_t    bus;
    mapper_typ_e typ;
    load_t       load;
    logic [7:0]  rdata;
    logic        rd_valid;

    // Reference state
    logic [7:0]  rom_img  [ROM_DEPTH];
    logic [7:0]  sram_img [SRAM_DEPTH];
    logic [5:0]  gm2_bank [4];                          // Entry 0 is the fixed window
    logic [5:0]  kon_bank [4];
    logic [5:0]  a8_bank  [4];
    mapper_typ_e cur_typ;                               // Updated without waiting for NBA
    logic [31:0] rng;

    int err_cnt  = 0;
    int chk_cnt  = 0;
    int test_cnt = 0;
    int err_base;
    int chk_base;
    int total_err;

    cart_slot_top dut (
        .cpu_bus  (cpu_bus),
        .arst_n   (arst_n),
        .bus      (bus),
        .typ      (typ),
        .load     (load),
        .rdata    (rdata),
        .rd_valid (rd_valid)
    );

    initial begin
        cpu_bus = 1'b0;
        forever #5 cpu_bus = ~cpu_bus;                 // 100 MHz
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [12:0] random_offset();
        rng = xorshift32(rng);
        return rng[12:0];                               // Offset inside an 8K window
    endfunction

    // Expected byte for a read in 4000h-BFFFh under the current mapper
    function automatic logic [7:0] model_read(input logic [15:0] a);
        logic [2:0]        page;
        logic [5:0]        b;
        logic [ROM_AW-1:0] idx;
        page = a[15:13] - 3'd2;                         // Window 0..3
        case (cur_typ)
            MAPPER_GM2:    b = gm2_bank[page[1:0]];
            MAPPER_KONAMI: b = kon_bank[page[1:0]];
            default:       b = a8_bank[page[1:0]];
        endcase
        if (cur_typ == MAPPER_GM2 && b[4]) begin
            return sram_img[{b[5], a[11:0]}];           // 4K SRAM page
        end
        idx = {b[3:0], a[12:0]};                        // Banks above 15 wrap in 128 KB
        return rom_img[idx];
    endfunction

    task automatic model_write(input logic [15:0] a, input logic [7:0] d);
        case (cur_typ)
            MAPPER_GM2: begin
                // SRAM store uses bank3 as it was before this write
                if (a[15:12] == 4'hB && gm2_bank[3][4]) begin
                    sram_img[{gm2_bank[3][5], a[11:0]}] = d;
                end
                case (a[15:12])
                    4'h6:    gm2_bank[1] = d[5:0];
                    4'h8:    gm2_bank[2] = d[5:0];
                    4'hA:    gm2_bank[3] = d[5:0];
                    default: ;
                endcase
            end
            MAPPER_KONAMI: begin
                case (a[15:13])
                    3'b011:  kon_bank[1] = d[5:0];
                    3'b100:  kon_bank[2] = d[5:0];
                    3'b101:  kon_bank[3] = d[5:0];
                    default: ;
                endcase
            end
            MAPPER_ASCII8: begin
                if (a[15:13] == 3'b011) begin
                    a8_bank[a[12:11]] = d[5:0];         // 2K select regions
                end
            end
            default: ;
        endcase
    endtask

    task automatic load_rom();
        logic [31:0]       x;
        logic [ROM_AW-1:0] ri;
        x = SEED;
        for (int i = 0; i < ROM_DEPTH; i++) begin
            x = xorshift32(x);
            ri = i[ROM_AW-1:0];
            rom_img[ri] = x[7:0];
            @(posedge cpu_bus);
            load <= '{valid: 1'b1, addr: {{(MEM_AW-ROM_AW){1'b0}}, ri}, data: x[7:0]};
        end
        @(posedge cpu_bus);
        load <= LOAD_IDLE;
        rng = x;                                        // Offsets continue the sequence
    endtask

    task automatic select_mapper(input mapper_typ_e t);
        @(posedge cpu_bus);
        typ <= t;
        cur_typ = t;
    endtask

    // One strobe cycle, DUT samples it on the edge this task returns on
    task automatic drive_access(input logic [15:0] a, input logic [7:0] d, input logic is_rd);
        @(posedge cpu_bus);
        bus <= '{addr: a, data: d, mreq: 1'b1, rd: is_rd, wr: !is_rd};
        @(posedge cpu_bus);
        bus <= BUS_IDLE;
    endtask

    task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
        drive_access(a, d, 1'b0);
        model_write(a, d);
    endtask

    task automatic check_read(input logic [15:0] a);
        logic [7:0] exp;
        int         waited;
        exp = model_read(a);
        drive_access(a, 8'h00, 1'b1);
        waited = 0;
        while (!rd_valid && waited < RD_TIMEOUT) begin
            @(posedge cpu_bus);
            waited++;
        end
        chk_cnt++;
        assert (rd_valid) else begin
            $display("Read at %h got no read data within %0d cycles", a, RD_TIMEOUT);
            err_cnt++;
        end
        if (rd_valid) begin
            assert (rdata === exp) else begin
                $display("[ERROR] %0t: read at %h returned %h, expected %h",
                         $time, a, rdata, exp);
                err_cnt++;
            end
        end
    endtask

    // Unmapped or disabled read, two quiet cycles
    task automatic check_no_read(input logic [15:0] a);
        drive_access(a, 8'h00, 1'b1);
        repeat (2) begin
            @(posedge cpu_bus);
            chk_cnt++;
            assert (!rd_valid) else begin
                $display("Read at %h with mapper %s raised rd_valid", a, cur_typ.name());
                err_cnt++;
            end
        end
    endtask

    task automatic read_windows(input int per_win);
        logic [2:0] page;
        for (int w = 0; w < 4; w++) begin
            page = 3'd2 + w[2:0];                       // 4000h, 6000h, 8000h, A000h
            for (int k = 0; k < per_win; k++) begin
                check_read({page, random_offset()});
            end
        end
    endtask

    task automatic begin_test();
        err_base = err_cnt;
        chk_base = chk_cnt;
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        $display("%s: %0d checks, %0d errors", name, chk_cnt - chk_base, err_cnt - err_base);
    endtask

    initial begin
        #(WD_NS);
        $display("Watchdog expired after %0d ns, the run did not complete", WD_NS);
        $display("test failed");
        $finish;
    end

    initial begin
        arst_n  = 1'b0;
        bus     = BUS_IDLE;
        typ     = MAPPER_NONE;
        load    = LOAD_IDLE;
        cur_typ = MAPPER_NONE;
        rng     = SEED;
        gm2_bank = '{6'd0, 6'd1, 6'd2, 6'd3};
        kon_bank = '{6'd0, 6'd1, 6'd2, 6'd3};
        a8_bank  = '{6'd0, 6'd0, 6'd0, 6'd0};
        repeat (16) @(posedge cpu_bus);
        arst_n <= 1'b1;

        load_rom();

        begin_test();
        select_mapper(MAPPER_GM2);
        read_windows(3);
        end_test("gm2_reset_defaults");

        begin_test();
        cpu_write(16'h6000, 8'h05);
        cpu_write(16'h8ABC, 8'h2B);                    // Bit 5 set, ROM uses bits 3:0
        cpu_write(16'hA5F0, 8'h0E);
        read_windows(3);
        cpu_write(16'h7000, 8'h09);                    // No register at 7xxxh
        read_windows(1);
        end_test("gm2_bank_switch");

        begin_test();
        cpu_write(16'hA000, 8'h10);                    // Bank3 on SRAM page 0
        cpu_write(16'hB123, 8'h5A);
        check_read(16'hB123);
        check_read(16'hA123);                          // Same byte through Axxxh
        cpu_write(16'hA123, 8'h10);                    // Register only, SRAM kept
        check_read(16'hB123);
        cpu_write(16'hA000, 8'h30);                    // Page 1
        cpu_write(16'hB123, 8'hC3);
        check_read(16'hB123);
        cpu_write(16'hA000, 8'h10);
        check_read(16'hB123);
        check_read({3'b011, random_offset()});         // ROM windows unaffected
        end_test("gm2_sram");

        begin_test();
        select_mapper(MAPPER_KONAMI);
        read_windows(2);
        cpu_write(16'h6000, 8'h07);
        cpu_write(16'h9FFF, 8'h0C);
        cpu_write(16'hA000, 8'h1F);                    // Wraps onto bank 15
        cpu_write(16'h5000, 8'h0A);                    // First window has no register
        read_windows(3);
        end_test("konami_switch");

        begin_test();
        select_mapper(MAPPER_ASCII8);
        read_windows(2);
        cpu_write(16'h6000, 8'h03);
        cpu_write(16'h6800, 8'h06);
        cpu_write(16'h7000, 8'h0A);
        cpu_write(16'h7FFF, 8'h2D);
        read_windows(3);
        end_test("ascii8_switch");

        begin_test();
        select_mapper(MAPPER_GM2);
        check_no_read(16'h0000);
        check_no_read(16'hC000);
        select_mapper(MAPPER_ASCII8);
        check_no_read(16'hC123);
        check_no_read(16'h3FFF);
        select_mapper(MAPPER_NONE);
        check_no_read(16'h4000);
        check_no_read(16'h8000);
        check_no_read(16'hA000);
        end_test("unmapped_disabled");

        total_err = err_cnt + int'(dut.u_mem.u_props.fail_cnt);
        $display("%0d tests, %0d checks, %0d check errors, %0d assertion failures",
                 test_cnt, chk_cnt, err_cnt, dut.u_mem.u_props.fail_cnt);
        if (total_err == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: flist.f
logic/cart_pkg.sv
logic/mapper_gamemaster2.sv
logic/mapper_konami.sv
logic/mapper_ascii8.sv
logic/cart_memory.sv
logic/cart_slot_top.sv
dv/cart_slot_properties.sv
dv/cart_slot_tb.sv

// File: logic/cart_memory.sv
// Slot-local memory behind the mappers
// Request merge, ROM image array, battery SRAM, one-cycle read path
`timescale 1ns/1ps

module cart_memory (
    input  logic                  cpu_bus,
    input  logic                  arst_n,
    input  cart_pkg::cpu_req_t    bus,
    input  cart_pkg::load_t       load,
    input  cart_pkg::mapper_out_t out_gm2,
    input  cart_pkg::mapper_out_t out_kon,
    input  cart_pkg::mapper_out_t out_a8,
    output logic [7:0]            rdata,
    output logic                  rd_valid
);
    import cart_pkg::*;

    localparam int ROM_DEPTH  = 2 ** ROM_AW;
    localparam int SRAM_DEPTH = 2 ** SRAM_AW;

    mapper_out_t        act;                     // Request of the enabled mapper
    logic               act_cs;
    logic               rd_hit;                  // Read to be answered next cycle
    logic               sram_we;
    logic [ROM_AW-1:0]  rom_idx;
    logic [SRAM_AW-1:0] sram_idx;
    logic [7:0]         rd_byte;

    logic [7:0] rom  [ROM_DEPTH];                // Cartridge image
    logic [7:0] sram [SRAM_DEPTH];               // Battery backed

    // Mapper types exclude each other, so at most one has a select
    always_comb begin
        if (out_gm2.ram_cs || out_gm2.sram_cs) begin
            act = out_gm2;
        end else if (out_kon.ram_cs || out_kon.sram_cs) begin
            act = out_kon;
        end else if (out_a8.ram_cs || out_a8.sram_cs) begin
            act = out_a8;
        end else begin
            act = '{addr: ADDR_IDLE, ram_cs: 1'b0, sram_cs: 1'b0, rnw: 1'b1};
        end
    end

    assign act_cs   = act.ram_cs || act.sram_cs;
    assign rd_hit   = act_cs && act.rnw && bus.rd;
    assign sram_we  = act.sram_cs && !act.rnw && bus.wr;  // Stores on this edge

    // Upper address bits beyond the arrays are dropped
    assign rom_idx  = act.addr[ROM_AW-1:0];
    assign sram_idx = act.addr[SRAM_AW-1:0];

    assign rd_byte  = act.sram_cs ? sram[sram_idx] : rom[rom_idx];

    // Loader fills the image
    always_ff @(posedge cpu_bus) begin
        if (load.valid) begin
            rom[load.addr[ROM_AW-1:0]] <= load.data;
        end
    end

    always_ff @(posedge cpu_bus) begin
        if (sram_we) begin
            sram[sram_idx] <= bus.data;
        end
    end

    // Read data appears one cycle after the strobe
    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            rdata    <= 8'h00;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_hit;                  // Single-cycle pulse per read
            if (rd_hit) begin
                rdata <= rd_byte;                // Held until the next read
            end
        end
    end

endmodule

// File: logic/cart_pkg.sv
// Shared types for the cartridge slot
// CPU bus, mapper request and ROM load structs, mapper type enum, memory sizes
package cart_pkg;

    // Memory geometry
    localparam int MEM_AW  = 27;                   // Mapper output address width
    localparam int ROM_AW  = 17;                   // 128 KB ROM, 16 banks of 8K
    localparam int SRAM_AW = 13;                   // 8 KB battery SRAM

    localparam logic [MEM_AW-1:0] ADDR_IDLE = {MEM_AW{1'b1}};  // Address when no mapper is active

    // Mapper selection, one per slot configuration
    typedef enum logic [1:0] {
        MAPPER_NONE   = 2'd0,                      // Slot empty
        MAPPER_GM2    = 2'd1,                      // GameMaster2 with SRAM
        MAPPER_KONAMI = 2'd2,                      // Konami, no SCC
        MAPPER_ASCII8 = 2'd3                       // ASCII 8K banks
    } mapper_typ_e;

    // One CPU memory cycle
    // Strobes are single-cycle, no wait states
    typedef struct packed {
        logic [15:0] addr;                         // Z80 address
        logic [7:0]  data;                         // Write data
        logic        mreq;                         // Memory request
        logic        rd;                           // Read strobe
        logic        wr;                           // Write strobe
    } cpu_req_t;

    // Request of one mapper towards slot memory
    typedef struct packed {
        logic [MEM_AW-1:0] addr;                   // ADDR_IDLE when idle
        logic              ram_cs;                 // ROM image select
        logic              sram_cs;                // Battery SRAM select
        logic              rnw;                    // Low only for SRAM write
    } mapper_out_t;

    // One byte of the ROM image from the loader
    typedef struct packed {
        logic              valid;                  // Byte present this cycle
        logic [MEM_AW-1:0] addr;                   // Image offset
        logic [7:0]        data;                   // Image byte
    } load_t;

    // Sizes as seen by the mappers
    // 8K bank window, 13 address bits below the bank number
    // GameMaster2 SRAM pages are 4K, selected by bank bit 5
    // Konami and ASCII8 forward the full 6-bit bank number
    // GameMaster2 keeps only bank bits 3:0 for ROM

endpackage

// File: logic/cart_slot_top.sv
// Cartridge slot top level
// Three mappers side by side, joined at the slot memory
`timescale 1ns/1ps

module cart_slot_top (
    input  logic                  cpu_bus,       // CPU clock
    input  logic                  arst_n,        // Async reset, active low
    input  cart_pkg::cpu_req_t    bus,           // CPU memory cycle
    input  cart_pkg::mapper_typ_e typ,           // Configured mapper
    input  cart_pkg::load_t       load,          // ROM image bytes
    output logic [7:0]            rdata,
    output logic                  rd_valid
);
    import cart_pkg::*;

    mapper_out_t out_gm2;                        // Each mapper decodes on its own
    mapper_out_t out_kon;
    mapper_out_t out_a8;

    mapper_gamemaster2 u_gm2 (
        .cpu_bus (cpu_bus),
        .arst_n  (arst_n),
        .bus     (bus),
        .typ     (typ),
        .out     (out_gm2)
    );

    mapper_konami u_kon (
        .cpu_bus (cpu_bus),
        .arst_n  (arst_n),
        .bus     (bus),
        .typ     (typ),
        .out     (out_kon)
    );

    mapper_ascii8 u_a8 (
        .cpu_bus (cpu_bus),
        .arst_n  (arst_n),
        .bus     (bus),
        .typ     (typ),
        .out     (out_a8)
    );

    // Only the enabled mapper raises a select
    cart_memory u_mem (
        .cpu_bus  (cpu_bus),
        .arst_n   (arst_n),
        .bus      (bus),
        .load     (load),
        .out_gm2  (out_gm2),
        .out_kon  (out_kon),
        .out_a8   (out_a8),
        .rdata    (rdata),
        .rd_valid (rd_valid)
    );

endmodule

// File: logic/mapper_ascii8.sv
// ASCII8 mapper
// Four switchable 8K banks, select registers in 2K regions at 6000h-7FFFh
`timescale 1ns/1ps

module mapper_ascii8 (
    input  logic                  cpu_bus,
    input  logic                  arst_n,
    input  cart_pkg::cpu_req_t    bus,
    input  cart_pkg::mapper_typ_e typ,
    output cart_pkg::mapper_out_t out
);
    import cart_pkg::*;

    logic            cs;
    logic            win_mapped;                 // 4000h-BFFFh
    logic            reg_wr;                     // Write into 6000h-7FFFh
    logic [3:0][5:0] bank;                       // One per window, 4000h first
    logic [1:0]      win_idx;                    // Window of current address
    logic [5:0]      bank_sel;

    assign cs         = (typ == MAPPER_ASCII8) && bus.mreq;
    assign win_mapped = bus.addr[15] ^ bus.addr[14];
    assign reg_wr     = cs && bus.wr && (bus.addr[15:13] == 3'b011);

    // 6000h, 6800h, 7000h, 7800h map onto addr[12:11]
    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            bank <= '0;                          // All windows start on bank 0
        end else if (reg_wr) begin
            bank[bus.addr[12:11]] <= bus.data[5:0];
        end
    end

    // 010 -> 0, 011 -> 1, 100 -> 2, 101 -> 3 inside the mapped range
    assign win_idx  = {bus.addr[15], bus.addr[13]};
    assign bank_sel = bank[win_idx];

    always_comb begin
        out.ram_cs  = cs && win_mapped && bus.rd;
        out.sram_cs = 1'b0;
        out.rnw     = 1'b1;                      // ROM is read only
        if (out.ram_cs) begin
            out.addr = {{(MEM_AW-19){1'b0}}, bank_sel, bus.addr[12:0]};
        end else begin
            out.addr = ADDR_IDLE;
        end
    end

endmodule

// File: logic/mapper_gamemaster2.sv
// GameMaster2 mapper
// Three switchable 8K ROM banks, SRAM pages selected by bank bit 4
`timescale 1ns/1ps

module mapper_gamemaster2 (
    input  logic                  cpu_bus,       // CPU clock
    input  logic                  arst_n,
    input  cart_pkg::cpu_req_t    bus,
    input  cart_pkg::mapper_typ_e typ,
    output cart_pkg::mapper_out_t out
);
    import cart_pkg::*;

    logic       mapper_en;                       // Slot configured as GM2
    logic       cs;                              // Access to this mapper
    logic       win_mapped;                      // 4000h-BFFFh
    logic [5:0] bank1, bank2, bank3;             // Switchable bank numbers
    logic [5:0] bank_sel;                        // Bank for current window
    logic       sram_en;
    logic       sram_wr;
    logic [MEM_AW-1:0] rom_addr;
    logic [MEM_AW-1:0] sram_addr;

    assign mapper_en  = (typ == MAPPER_GM2);
    assign cs         = mapper_en && bus.mreq;
    assign win_mapped = bus.addr[15] ^ bus.addr[14];  // Pages 1 and 2 only

    // Bank registers, written anywhere in the 4K region
    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            bank1 <= 6'd1;
            bank2 <= 6'd2;
            bank3 <= 6'd3;
        end else if (cs && bus.wr) begin
            case (bus.addr[15:12])
                4'h6:    bank1 <= bus.data[5:0];
                4'h8:    bank2 <= bus.data[5:0];
                4'hA:    bank3 <= bus.data[5:0];
                default: ;                       // Other writes ignored
            endcase
        end
    end

    // Window decode
    always_comb begin
        case (bus.addr[15:13])
            3'b010:  bank_sel = 6'd0;            // 4000h fixed
            3'b011:  bank_sel = bank1;           // 6000h
            3'b100:  bank_sel = bank2;           // 8000h
            default: bank_sel = bank3;           // A000h, unmapped masked later
        endcase
    end

    // ROM keeps bank bits 3:0, SRAM uses bit 5 as 4K page
    assign rom_addr  = {{(MEM_AW-17){1'b0}}, bank_sel[3:0], bus.addr[12:0]};
    assign sram_addr = {{(MEM_AW-13){1'b0}}, bank_sel[5], bus.addr[11:0]};

    assign sram_en = bank_sel[4];
    // Only Bxxxh writes reach the SRAM
    // Axxxh writes go to the bank register only
    assign sram_wr = bus.wr && (bus.addr[15:12] == 4'hB);

    always_comb begin
        out.ram_cs  = cs && win_mapped && !sram_en && bus.rd;
        out.sram_cs = cs && win_mapped && sram_en;
        out.rnw     = !(out.sram_cs && sram_wr);
        if (out.sram_cs) begin
            out.addr = sram_addr;
        end else if (out.ram_cs) begin
            out.addr = rom_addr;
        end else begin
            out.addr = ADDR_IDLE;                // Nothing selected
        end
    end

endmodule

// File: logic/mapper_konami.sv
// Konami mapper without sound
// Fixed first 8K bank, three switchable 8K banks, ROM only
`timescale 1ns/1ps

module mapper_konami (
    input  logic                  cpu_bus,
    input  logic                  arst_n,
    input  cart_pkg::cpu_req_t    bus,
    input  cart_pkg::mapper_typ_e typ,
    output cart_pkg::mapper_out_t out
);
    import cart_pkg::*;

    logic       cs;                              // Konami active and mreq
    logic       win_mapped;
    logic [5:0] bank1, bank2, bank3;
    logic [5:0] bank_sel;

    assign cs         = (typ == MAPPER_KONAMI) && bus.mreq;
    assign win_mapped = bus.addr[15] ^ bus.addr[14];

    // Register written anywhere in its own 8K window
    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            bank1 <= 6'd1;
            bank2 <= 6'd2;
            bank3 <= 6'd3;
        end else if (cs && bus.wr) begin
            case (bus.addr[15:13])
                3'b011:  bank1 <= bus.data[5:0];  // 6000h-7FFFh
                3'b100:  bank2 <= bus.data[5:0];  // 8000h-9FFFh
                3'b101:  bank3 <= bus.data[5:0];  // A000h-BFFFh
                default: ;
            endcase
        end
    end

    always_comb begin
        case (bus.addr[15:13])
            3'b011:  bank_sel = bank1;
            3'b100:  bank_sel = bank2;
            3'b101:  bank_sel = bank3;
            default: bank_sel = 6'd0;            // 4000h stays on bank 0
        endcase
    end

    // Reads only, full bank number forwarded
    always_comb begin
        out.ram_cs  = cs && win_mapped && bus.rd;
        out.sram_cs = 1'b0;                      // No SRAM on this board
        out.rnw     = 1'b1;
        out.addr    = out.ram_cs ? {{(MEM_AW-19){1'b0}}, bank_sel, bus.addr[12:0]}
                                 : ADDR_IDLE;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the cartridge slot testbench with Verilator.
# Exit status is zero only when the run prints the pass message.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=cart_slot_sim

verilator --binary --timing --assert -j 0 \
    --top-module cart_slot_tb \
    --Mdir "$BUILD_DIR" -o "$SIM_EXE" \
    -f flist.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Let every assertion failure be reported before the run ends
output=$("./$BUILD_DIR/$SIM_EXE" +verilator+error+limit+1000 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi
